/* build.f */
+incdir+include
rtl/itch_pkg.sv
rtl/itch_msg_framer.sv
rtl/itch_field_extract.sv
rtl/itch_order_queue.sv
rtl/itch_parser_top.sv
verification/itch_parser_tb.sv

/* build.sh */
#!/usr/bin/env bash
# Build the ITCH parser testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f build.f --top-module itch_parser_tb -o itch_parser_sim

# The simulation exits non-zero on any $fatal
./obj_dir/itch_parser_sim

/* include/itch_macros.svh */
`ifndef ITCH_MACROS_SVH
`define ITCH_MACROS_SVH

// Buffer depths and credit counts
`define ITCH_IN_DEPTH        4      // Input byte FIFO, also source credits after reset
`define ITCH_OUT_DEPTH       4      // Order queue entries
`define ITCH_OUT_CREDITS     2      // Receiver slots

// Message type codes
`define ITCH_TYPE_A          8'h41  // Add order
`define ITCH_TYPE_F          8'h46  // Add order with MPID
`define ITCH_TYPE_E          8'h45  // Order executed
`define ITCH_TYPE_C          8'h43  // Order executed with price
`define ITCH_TYPE_X          8'h58  // Order cancel
`define ITCH_TYPE_D          8'h44  // Order delete

`define ITCH_NOT_PRINTABLE   8'h4E  // 'N'

// Field offsets, type byte is byte 0, fields are big endian
`define ITCH_OFS_REF         15
`define ITCH_OFS_SIDE        19     // Bit 0 set means sell
`define ITCH_OFS_ADD_SHARES  20
`define ITCH_OFS_STOCK       24
`define ITCH_OFS_EXEC_SHARES 19
`define ITCH_OFS_PRICE       32
`define ITCH_OFS_PRINTABLE   31

// Every field spans this many bytes
`define ITCH_FIELD_BYTES     4

`endif

/* rtl/itch_field_extract.sv */
`include "itch_macros.svh"

module itch_field_extract (
    input  logic                 clk,
    input  logic                 reset_n,
    input  itch_pkg::byte_beat_t beat_i,
    input  logic                 beat_valid_i,
    input  logic                 queue_full_i,
    output logic                 beat_ready_o,
    output itch_pkg::order_t     order_o,
    output logic                 order_push_o
);
    import itch_pkg::*;

    order_t order_q;
    logic   drop_q;
    logic   push_q;
    logic   beat_xfer;
    logic   hit_printable;
    logic   drop_now;
    logic   order_ok;

    // True when idx lies inside the field starting at ofs
    function automatic logic in_field(input byte_idx_t idx, input int ofs);
        return (idx >= byte_idx_t'(ofs)) &&
               (idx <= byte_idx_t'(ofs + `ITCH_FIELD_BYTES - 1));
    endfunction

    function automatic field_t shift_in(input field_t f, input itch_byte_t b);
        return {f[23:0], b};    // Most significant byte arrives first
    endfunction

    function automatic order_kind_e to_order_kind(input msg_kind_e k);
        case (k)
            KIND_ADD:                   return ORDER_ADD;
            KIND_EXEC, KIND_EXEC_PRICE: return ORDER_EXECUTE;
            KIND_CANCEL:                return ORDER_CANCEL;
            KIND_DELETE:                return ORDER_DELETE;
            default:                    return ORDER_ERROR;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Handshake and emit decision
    ////////////////////////////////////////////////////////////

    // Only the closing beat needs room in the queue
    assign beat_ready_o = !(beat_valid_i && beat_i.last && queue_full_i);
    assign beat_xfer    = beat_valid_i && beat_ready_o;

    assign hit_printable = (beat_i.kind == KIND_EXEC_PRICE) &&
                           (beat_i.idx == byte_idx_t'(`ITCH_OFS_PRINTABLE)) &&
                           (beat_i.data == `ITCH_NOT_PRINTABLE);

    // The type byte starts a fresh message, so an old drop is forgotten
    assign drop_now = ((beat_i.idx != '0) && drop_q) || hit_printable;
    assign order_ok = (beat_i.kind != KIND_OTHER) && !drop_now;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            drop_q <= 1'b0;
            push_q <= 1'b0;
        end else begin
            if (beat_xfer) drop_q <= drop_now;
            push_q <= beat_xfer && beat_i.last && order_ok;
        end
    end

    ////////////////////////////////////////////////////////////
    // Field assembly
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (beat_xfer) begin
            if (beat_i.idx == '0) begin
                order_q      <= '0;  // Bytes never carried stay zero
                order_q.kind <= to_order_kind(beat_i.kind);
            end else begin
                if (beat_i.kind != KIND_OTHER && in_field(beat_i.idx, `ITCH_OFS_REF))
                    order_q.order_ref <= shift_in(order_q.order_ref, beat_i.data);
                case (beat_i.kind)
                    KIND_ADD: begin
                        if (beat_i.idx == byte_idx_t'(`ITCH_OFS_SIDE))
                            order_q.sell <= beat_i.data[0];
                        if (in_field(beat_i.idx, `ITCH_OFS_ADD_SHARES))
                            order_q.shares <= shift_in(order_q.shares, beat_i.data);
                        if (in_field(beat_i.idx, `ITCH_OFS_STOCK))
                            order_q.stock_id <= shift_in(order_q.stock_id, beat_i.data);
                        if (in_field(beat_i.idx, `ITCH_OFS_PRICE))
                            order_q.price <= shift_in(order_q.price, beat_i.data);
                    end
                    KIND_EXEC, KIND_CANCEL: begin
                        if (in_field(beat_i.idx, `ITCH_OFS_EXEC_SHARES))
                            order_q.shares <= shift_in(order_q.shares, beat_i.data);
                    end
                    KIND_EXEC_PRICE: begin
                        if (in_field(beat_i.idx, `ITCH_OFS_EXEC_SHARES))
                            order_q.shares <= shift_in(order_q.shares, beat_i.data);
                        if (in_field(beat_i.idx, `ITCH_OFS_PRICE))
                            order_q.price <= shift_in(order_q.price, beat_i.data);
                    end
                    default: ;  // Delete carries the reference only
                endcase
            end
        end
    end

    assign order_o      = order_q;
    assign order_push_o = push_q;

    // Holding the last beat must keep pushes away from a full queue
    a_push_not_full: assert property (@(posedge clk) disable iff (!reset_n)
        order_push_o |-> !queue_full_i)
        else $error("order pushed while the queue was full");

endmodule

/* rtl/itch_msg_framer.sv */
`include "itch_macros.svh"

module itch_msg_framer (
    input  logic                   clk,
    input  logic                   reset_n,
    input  itch_pkg::itch_byte_t   byte_i,
    input  logic                   byte_valid_i,
    output logic                   byte_credit_o,
    output itch_pkg::byte_beat_t   beat_o,
    output logic                   beat_valid_o,
    input  logic                   beat_ready_i
);
    import itch_pkg::*;

    localparam int DEPTH = `ITCH_IN_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    itch_byte_t       fifo_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] fifo_cnt;
    logic             fifo_empty, fifo_full;
    logic             fifo_push, fifo_pop;
    itch_byte_t       head;

    framer_state_e    state_q;
    msg_len_t         len_q;
    byte_idx_t        idx_q;
    byte_idx_t        cur_idx;
    msg_kind_e        kind_q, type_kind;
    logic             beat_xfer;
    logic             credit_q;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////
    // Byte FIFO
    ////////////////////////////////////////////////////////////
    assign head       = fifo_mem[rd_ptr];
    assign fifo_empty = (fifo_cnt == '0);
    assign fifo_full  = (fifo_cnt == CNT_W'(DEPTH));
    assign fifo_push  = byte_valid_i && !fifo_full;

    // Length bytes are consumed here, everything else waits for the extractor
    assign fifo_pop = beat_xfer || (state_q == WAIT_LENGTH && !fifo_empty);

    always_ff @(posedge clk) begin
        if (fifo_push) fifo_mem[wr_ptr] <= byte_i;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
            credit_q <= 1'b0;
        end else begin
            if (fifo_push) wr_ptr <= ptr_inc(wr_ptr);
            if (fifo_pop)  rd_ptr <= ptr_inc(rd_ptr);
            fifo_cnt <= fifo_cnt + CNT_W'(fifo_push) - CNT_W'(fifo_pop);
            credit_q <= fifo_pop;   // One credit back per consumed byte
        end
    end

    assign byte_credit_o = credit_q;

    ////////////////////////////////////////////////////////////
    // Type decode and beat build
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (head)
            `ITCH_TYPE_A, `ITCH_TYPE_F: type_kind = KIND_ADD;
            `ITCH_TYPE_E:               type_kind = KIND_EXEC;
            `ITCH_TYPE_C:               type_kind = KIND_EXEC_PRICE;
            `ITCH_TYPE_X:               type_kind = KIND_CANCEL;
            `ITCH_TYPE_D:               type_kind = KIND_DELETE;
            default:                    type_kind = KIND_OTHER;
        endcase
    end

    assign cur_idx = (state_q == WAIT_TYPE) ? '0 : idx_q;

    always_comb begin
        beat_o.data = head;
        beat_o.idx  = cur_idx;
        beat_o.kind = (state_q == WAIT_TYPE) ? type_kind : kind_q;
        beat_o.last = (cur_idx == len_q - 1'b1);
    end

    assign beat_valid_o = !fifo_empty && (state_q != WAIT_LENGTH);
    assign beat_xfer    = beat_valid_o && beat_ready_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= WAIT_LENGTH;
            len_q   <= '0;
            idx_q   <= '0;
            kind_q  <= KIND_OTHER;
        end else begin
            case (state_q)
                WAIT_LENGTH: begin
                    if (!fifo_empty && head != '0) begin    // Zero length is dropped
                        len_q   <= head;
                        state_q <= WAIT_TYPE;
                    end
                end
                WAIT_TYPE: begin
                    if (beat_xfer) begin
                        kind_q  <= type_kind;
                        idx_q   <= 8'd1;
                        state_q <= beat_o.last ? WAIT_LENGTH : IN_BODY;
                    end
                end
                IN_BODY: begin
                    if (beat_xfer) begin
                        idx_q <= idx_q + 1'b1;
                        if (beat_o.last) state_q <= WAIT_LENGTH;
                    end
                end
                default: state_q <= WAIT_LENGTH;
            endcase
        end
    end

    // Source must respect its byte credits
    a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
        byte_valid_i |-> !fifo_full)
        else $error("byte arrived while the input FIFO was full");

endmodule

/* rtl/itch_order_queue.sv */
`include "itch_macros.svh"

module itch_order_queue (
    input  logic             clk,
    input  logic             reset_n,
    input  itch_pkg::order_t order_i,
    input  logic             order_push_i,
    output logic             queue_full_o,
    output itch_pkg::order_t order_o,
    output logic             order_valid_o,
    input  logic             order_credit_i
);
    import itch_pkg::*;

    localparam int DEPTH   = `ITCH_OUT_DEPTH;
    localparam int CREDITS = `ITCH_OUT_CREDITS;
    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W   = $clog2(DEPTH + 1);
    localparam int CRD_W   = $clog2(CREDITS + 1);

    order_t           q_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] q_cnt;
    logic [CRD_W-1:0] crd_q;
    logic [CRD_W:0]   crd_sum;   // One bit wider to catch over-return
    logic             push, send;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////
    // Order FIFO
    ////////////////////////////////////////////////////////////
    assign queue_full_o = (q_cnt == CNT_W'(DEPTH));
    assign push         = order_push_i && !queue_full_o;
    assign send         = (q_cnt != '0) && (crd_q != '0);  // Head leaves when a slot is free

    always_ff @(posedge clk) begin
        if (push) q_mem[wr_ptr] <= order_i;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_cnt  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (send) rd_ptr <= ptr_inc(rd_ptr);
            q_cnt <= q_cnt + CNT_W'(push) - CNT_W'(send);
        end
    end

    assign order_o       = q_mem[rd_ptr];
    assign order_valid_o = send;

    ////////////////////////////////////////////////////////////
    // Receiver credits
    ////////////////////////////////////////////////////////////
    assign crd_sum = {1'b0, crd_q} + (CRD_W + 1)'(order_credit_i) - (CRD_W + 1)'(send);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            crd_q <= CRD_W'(CREDITS);
        end else begin
            crd_q <= (crd_sum > (CRD_W + 1)'(CREDITS)) ? CRD_W'(CREDITS)
                                                      : crd_sum[CRD_W-1:0];
        end
    end

    // Receiver never returns more credits than orders it was sent
    a_credit_bound: assert property (@(posedge clk) disable iff (!reset_n)
        crd_sum <= (CRD_W + 1)'(CREDITS))
        else $error("order credit count above receiver capacity");

endmodule

/* rtl/itch_parser_top.sv */
module itch_parser_top (
    input  logic                 clk,
    input  logic                 reset_n,
    input  itch_pkg::itch_byte_t byte_i,
    input  logic                 byte_valid_i,
    output logic                 byte_credit_o,
    output itch_pkg::order_t     order_o,
    output logic                 order_valid_o,
    input  logic                 order_credit_i
);
    import itch_pkg::*;

    byte_beat_t beat;
    logic       beat_valid;
    logic       beat_ready;
    order_t     order;
    logic       order_push;
    logic       queue_full;

    // Input side
    itch_msg_framer u_itch_msg_framer (
        .clk           (clk),
        .reset_n       (reset_n),
        .byte_i        (byte_i),
        .byte_valid_i  (byte_valid_i),
        .byte_credit_o (byte_credit_o),
        .beat_o        (beat),
        .beat_valid_o  (beat_valid),
        .beat_ready_i  (beat_ready)
    );

    itch_field_extract u_itch_field_extract (
        .clk          (clk),
        .reset_n      (reset_n),
        .beat_i       (beat),
        .beat_valid_i (beat_valid),
        .queue_full_i (queue_full),
        .beat_ready_o (beat_ready),
        .order_o      (order),
        .order_push_o (order_push)
    );

    // Output side
    itch_order_queue u_itch_order_queue (
        .clk            (clk),
        .reset_n        (reset_n),
        .order_i        (order),
        .order_push_i   (order_push),
        .queue_full_o   (queue_full),
        .order_o        (order_o),
        .order_valid_o  (order_valid_o),
        .order_credit_i (order_credit_i)
    );

endmodule

/* rtl/itch_pkg.sv */
package itch_pkg;

    typedef logic [7:0]  itch_byte_t;   // One message byte
    typedef logic [7:0]  msg_len_t;     // Length including the type byte
    typedef logic [7:0]  byte_idx_t;    // Type byte is index 0
    typedef logic [31:0] field_t;       // One order field

    // Message class decoded from the type byte
    typedef enum logic [2:0] {
        KIND_ADD,           // A and F
        KIND_EXEC,          // E
        KIND_EXEC_PRICE,    // C
        KIND_CANCEL,        // X
        KIND_DELETE,        // D
        KIND_OTHER          // Skipped
    } msg_kind_e;

    // Order type as reported downstream
    typedef enum logic [3:0] {
        ORDER_ERROR   = 4'h0,
        ORDER_ADD     = 4'h1,
        ORDER_CANCEL  = 4'h2,
        ORDER_EXECUTE = 4'h4,
        ORDER_DELETE  = 4'h8
    } order_kind_e;

    typedef enum logic [1:0] {
        WAIT_LENGTH,
        WAIT_TYPE,
        IN_BODY
    } framer_state_e;

    typedef struct packed {
        itch_byte_t data;
        byte_idx_t  idx;
        msg_kind_e  kind;
        logic       last;   // Final byte of the message
    } byte_beat_t;

    typedef struct packed {
        order_kind_e kind;
        logic        sell;
        field_t      stock_id;
        field_t      order_ref;
        field_t      shares;
        field_t      price;
    } order_t;

endpackage

/* verification/itch_parser_tb.sv */
`include "itch_macros.svh"

module itch_parser_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import itch_pkg::*;

    typedef itch_byte_t msg_q_t [$];

    localparam int IN_DEPTH    = `ITCH_IN_DEPTH;
    localparam int OUT_CREDITS = `ITCH_OUT_CREDITS;
    localparam int BYTE_LIMIT  = 500;   // Cycles a byte may wait for a credit
    localparam int DRAIN_LIMIT = 2000;
    localparam int STALL_LIMIT = 1000;

    logic       clk;
    logic       reset_n;
    itch_byte_t byte_i;
    logic       byte_valid_i;
    logic       byte_credit_o;
    order_t     order_o;
    logic       order_valid_o;
    logic       order_credit_i;

    integer     seed = 32'h47e5_802c;
    string      test_name = "reset";
    order_t     expected [$];           // Orders the reference model predicts
    order_t     exp_o;
    int         bytes_sent = 0;
    int         credits_back = 0;       // Byte credits seen from the DUT
    int         orders_seen = 0;
    int         credits_given = 0;      // Order credits returned by the receiver
    logic       hold_credits = 1'b0;
    logic       random_delay = 1'b0;
    int         credit_delay = 0;
    logic       sending_done;

    itch_parser_top u_itch_parser_top (
        .clk            (clk),
        .reset_n        (reset_n),
        .byte_i         (byte_i),
        .byte_valid_i   (byte_valid_i),
        .byte_credit_o  (byte_credit_o),
        .order_o        (order_o),
        .order_valid_o  (order_valid_o),
        .order_credit_i (order_credit_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    ////////////////////////////////////////////////////////////
    task automatic stop_run(input string why);
        $display("ERRORS FOUND");
        $fatal(1, "%s", why);
    endtask

    task automatic check_order(input string what, input order_t exp, input order_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", what, exp, act);
            stop_run("order mismatch");
        end
    endtask

    task automatic check_credit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", what, exp, act);
            stop_run("credit signal mismatch");
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("[ERROR] %s: expected %0d, actual %0d", what, exp, act);
            stop_run("count mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic itch_byte_t byte_at(input msg_q_t m, input int i);
        return (i < m.size()) ? m[i] : 8'h00;
    endfunction

    // A field reads its carried bytes big endian, absent bytes add nothing
    function automatic field_t field_at(input msg_q_t m, input int ofs);
        field_t v;
        v = '0;
        for (int i = 0; i < `ITCH_FIELD_BYTES; i++) begin
            if (ofs + i < m.size()) v = {v[23:0], m[ofs + i]};
        end
        return v;
    endfunction

    function automatic bit ref_order(input msg_q_t m, output order_t o);
        itch_byte_t t;
        o = '0;
        if (m.size() == 0) return 1'b0;
        t = m[0];
        case (t)
            `ITCH_TYPE_A, `ITCH_TYPE_F: o.kind = ORDER_ADD;
            `ITCH_TYPE_E, `ITCH_TYPE_C: o.kind = ORDER_EXECUTE;
            `ITCH_TYPE_X:               o.kind = ORDER_CANCEL;
            `ITCH_TYPE_D:               o.kind = ORDER_DELETE;
            default:                    return 1'b0;
        endcase
        o.order_ref = field_at(m, `ITCH_OFS_REF);
        if (o.kind == ORDER_ADD) begin
            o.sell     = byte_at(m, `ITCH_OFS_SIDE) & 8'h01;
            o.shares   = field_at(m, `ITCH_OFS_ADD_SHARES);
            o.stock_id = field_at(m, `ITCH_OFS_STOCK);
            o.price    = field_at(m, `ITCH_OFS_PRICE);
        end else if (t != `ITCH_TYPE_D) begin
            o.shares = field_at(m, `ITCH_OFS_EXEC_SHARES);
        end
        if (t == `ITCH_TYPE_C) begin
            o.price = field_at(m, `ITCH_OFS_PRICE);
            if (byte_at(m, `ITCH_OFS_PRINTABLE) == `ITCH_NOT_PRINTABLE) return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic int full_len(input itch_byte_t t);
        case (t)
            `ITCH_TYPE_A: return 36;
            `ITCH_TYPE_F: return 40;
            `ITCH_TYPE_E: return 31;
            `ITCH_TYPE_C: return 36;
            `ITCH_TYPE_X: return 23;
            `ITCH_TYPE_D: return 19;
            default:      return 20;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    function automatic int in_flight();
        return bytes_sent - credits_back;
    endfunction

    // Type byte first, random body bytes after it
    task automatic make_msg(input itch_byte_t t, input int len, output msg_q_t m);
        m = {};
        if (len > 0) m.push_back(t);
        for (int i = 1; i < len; i++) m.push_back(itch_byte_t'($random(seed)));
    endtask

    // Entered and left at 1 ns after a rising edge
    task automatic send_byte(input itch_byte_t b);
        int n;
        n = 0;
        while (in_flight() >= IN_DEPTH) begin
            byte_valid_i = 1'b0;
            @(posedge clk);
            #1;
            n++;
            if (n > BYTE_LIMIT) stop_run("timeout waiting for a byte credit");
        end
        byte_i       = b;
        byte_valid_i = 1'b1;
        bytes_sent++;
        @(posedge clk);
        #1;
        byte_valid_i = 1'b0;
    endtask

    task automatic send_msg(input msg_q_t m);
        order_t o;
        if (ref_order(m, o)) expected.push_back(o);
        send_byte(itch_byte_t'(m.size()));     // Length byte
        foreach (m[i]) send_byte(m[i]);
    endtask

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        while (expected.size() != 0 || credits_back < bytes_sent ||
               credits_given < orders_seen) begin
            @(posedge clk);
            #1;
            n++;
            if (n > DRAIN_LIMIT) stop_run({"timeout waiting for ", what, " to drain"});
        end
        repeat (8) @(posedge clk);
        #1;
        check_count({what, " byte credits"}, bytes_sent, credits_back);
    endtask

    ////////////////////////////////////////////////////////////
    // Monitors and receiver
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (reset_n && byte_credit_o) credits_back++;
    end

    always @(negedge clk) begin
        if (reset_n && order_valid_o) begin
            if (expected.size() == 0) stop_run("an order arrived when none was expected");
            exp_o = expected.pop_front();
            check_order(test_name, exp_o, order_o);
            orders_seen++;
            if (orders_seen - credits_given > OUT_CREDITS)
                stop_run("an order was sent without an order credit");
        end
    end

    initial begin : receiver
        int gap;
        gap            = 0;
        order_credit_i = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            order_credit_i = 1'b0;
            if (!hold_credits && orders_seen > credits_given) begin
                if (gap >= credit_delay) begin
                    order_credit_i = 1'b1;  // One order retired
                    credits_given++;
                    gap = 0;
                    if (random_delay) credit_delay = $unsigned($random(seed)) % 6;
                end else begin
                    gap++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin : main
        msg_q_t m;
        int     seen0;
        int     quiet;
        int     last_back;
        int     n;
        int     r;
        int     len;
        itch_byte_t t;

        reset_n      = 1'b0;
        byte_i       = '0;
        byte_valid_i = 1'b0;
        sending_done = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_credit("byte credit in reset", 1'b0, byte_credit_o);
            check_credit("order valid in reset", 1'b0, order_valid_o);
        end
        @(posedge clk);
        #1;
        reset_n = 1'b1;
        repeat (5) begin
            @(negedge clk);
            check_credit("byte credit while idle", 1'b0, byte_credit_o);
            check_credit("order valid while idle", 1'b0, order_valid_o);
        end
        check_count("credits before any byte", 0, credits_back);
        @(posedge clk);
        #1;
        make_msg(8'h5A, 3, m);                  // Four bytes fit the initial credits
        send_msg(m);
        wait_drain("reset");

        test_name = "add";
        make_msg(`ITCH_TYPE_A, 36, m);
        m[`ITCH_OFS_SIDE] = 8'h53;              // 'S' sell
        send_msg(m);
        make_msg(`ITCH_TYPE_F, 40, m);
        m[`ITCH_OFS_SIDE] = 8'h42;              // 'B' buy
        send_msg(m);
        make_msg(`ITCH_TYPE_A, 24, m);          // Ends after shares
        send_msg(m);
        wait_drain("add");

        test_name = "exec_cancel_delete";
        make_msg(`ITCH_TYPE_E, 31, m);
        send_msg(m);
        make_msg(`ITCH_TYPE_X, 23, m);
        send_msg(m);
        make_msg(`ITCH_TYPE_D, 19, m);
        send_msg(m);
        make_msg(`ITCH_TYPE_C, 36, m);
        m[`ITCH_OFS_PRINTABLE] = 8'h59;         // 'Y'
        send_msg(m);
        make_msg(`ITCH_TYPE_C, 36, m);
        m[`ITCH_OFS_PRINTABLE] = `ITCH_NOT_PRINTABLE;
        send_msg(m);
        make_msg(`ITCH_TYPE_E, 31, m);          // Follows a dropped C
        send_msg(m);
        wait_drain("exec_cancel_delete");

        test_name = "skip";
        make_msg(8'h00, 0, m);
        send_msg(m);
        make_msg(8'h5A, 10, m);
        send_msg(m);
        make_msg(`ITCH_TYPE_A, 36, m);
        send_msg(m);
        make_msg(8'h52, 1, m);
        send_msg(m);
        make_msg(8'h00, 0, m);
        send_msg(m);
        send_msg(m);
        make_msg(`ITCH_TYPE_D, 19, m);
        send_msg(m);
        make_msg(8'h51, 40, m);
        send_msg(m);
        make_msg(`ITCH_TYPE_E, 31, m);
        send_msg(m);
        wait_drain("skip");

        // Credits withheld until the whole chain stalls
        test_name    = "backpressure";
        hold_credits = 1'b1;
        seen0        = orders_seen;
        fork
            begin : bp_sender
                msg_q_t bm;
                for (int i = 0; i < 10; i++) begin
                    make_msg((i % 2 == 0) ? `ITCH_TYPE_A : `ITCH_TYPE_C, 36, bm);
                    send_msg(bm);
                end
                sending_done = 1'b1;
            end
        join_none
        quiet     = 0;
        n         = 0;
        last_back = credits_back;
        while (quiet < 20) begin
            @(posedge clk);
            #1;
            quiet     = (credits_back == last_back) ? quiet + 1 : 0;  // No byte credit returned
            last_back = credits_back;
            n++;
            if (n > STALL_LIMIT) stop_run("timeout waiting for the input side to stall");
        end
        check_count("orders sent without credit", OUT_CREDITS, orders_seen - seen0);
        check_count("bytes held at stall", IN_DEPTH, in_flight());
        hold_credits = 1'b0;
        n = 0;
        while (!sending_done) begin
            @(posedge clk);
            #1;
            n++;
            if (n > DRAIN_LIMIT) stop_run("timeout waiting for the held messages to be sent");
        end
        wait_drain("backpressure");

        test_name    = "random";
        random_delay = 1'b1;
        credit_delay = $unsigned($random(seed)) % 6;
        for (int i = 0; i < 200; i++) begin
            r = $unsigned($random(seed)) % 8;
            case (r)
                0:       t = `ITCH_TYPE_A;
                1:       t = `ITCH_TYPE_F;
                2:       t = `ITCH_TYPE_E;
                3:       t = `ITCH_TYPE_C;
                4:       t = `ITCH_TYPE_X;
                5:       t = `ITCH_TYPE_D;
                default: t = 8'h50 + itch_byte_t'($unsigned($random(seed)) % 4);
            endcase
            if (r == 7)
                len = 0;
            else if ($random(seed) & 1)
                len = full_len(t);
            else
                len = 1 + $unsigned($random(seed)) % 40;
            make_msg(t, len, m);
            if (t == `ITCH_TYPE_C && len > `ITCH_OFS_PRINTABLE)
                m[`ITCH_OFS_PRINTABLE] = ($random(seed) & 1) ? 8'h59 : `ITCH_NOT_PRINTABLE;
            send_msg(m);
        end
        wait_drain("random");

        if (expected.size() != 0) begin
            stop_run("expected orders were never received");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule
